//--- build.f
common/axi_line_pkg.sv
common/cmd_reg_pkg.sv
axi_mstr/cmd_regs.sv
axi_mstr/axi_mstr_fsm.sv
hw/line_mem.sv
hw/dma_mstr_top.sv
test/tb_dma_mstr_top.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run; exit status follows the testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f build.f --top-module tb_dma_mstr_top -o tb_dma_mstr_top \
   && ./obj_dir/tb_dma_mstr_top \
   || exit 1

//--- test/tb_dma_mstr_top.sv
// Register-driven AXI master testbench
`timescale 1ns/1ps
`default_nettype none

module tb_dma_mstr_top
   import cmd_reg_pkg::*;
();

   localparam int N_ENTRIES    = 8;
   localparam int N_LANE_LINES = 3;
   localparam int ACK_TIMEOUT  = 20;
   localparam int POLL_LIMIT   = 50;

   // One write-then-read command pair
   typedef struct packed {
      logic [31:0] addr_hi;
      logic [3:0]  line;
      logic [5:0]  ofs;
      logic [31:0] wr_word;
      logic [31:0] exp_word;
   } entry_t;

   logic        aclk;
   logic        aresetn;
   logic [31:0] cfg_addr;
   logic [31:0] cfg_wdata;
   logic        cfg_wr;
   logic        cfg_rd;
   logic        cfg_ack;
   logic [31:0] cfg_rdata;

   entry_t       tbl [N_ENTRIES];
   // Reference copy of the line memory
   logic [511:0] ref_mem [16];
   logic [31:0]  seed;
   cmd_reg_t     all_regs [5] = '{CCR, CAHR, CALR, CWDR, CRDR};

   dma_mstr_top #(
      .MEM_LINES (16)
   ) uut (
      .aclk, .aresetn,
      .cfg_addr, .cfg_wdata, .cfg_wr, .cfg_rd, .cfg_ack, .cfg_rdata
   );

   initial begin
      aclk = 1'b0;
      forever #5 aclk = ~aclk;
   end

   // ------------------------------------------------
   // Helpers
   // ------------------------------------------------
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Low address word from line index and lane
   function automatic logic [31:0] line_lo(input logic wrap, input logic [3:0] line,
                                           input logic [5:0] ofs);
      return {21'h0, wrap, line, ofs};
   endfunction

   // Byte merge of one word into the model
   task automatic model_write(input logic [3:0] line, input logic [5:0] ofs,
                              input logic [31:0] word);
      int b;
      int pos;
      for (b = 0; b < 4; b++) begin
         pos = (int'(ofs) + b) * 8;
         ref_mem[line][pos +: 8] = word[b*8 +: 8];
      end
   endtask

   function automatic logic [31:0] model_read(input logic [3:0] line, input logic [5:0] ofs);
      logic [31:0] word;
      int          b;
      int          pos;
      for (b = 0; b < 4; b++) begin
         pos = (int'(ofs) + b) * 8;
         word[b*8 +: 8] = ref_mem[line][pos +: 8];
      end
      return word;
   endfunction

   task automatic stop_with_failure();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
         stop_with_failure();
      end
   endtask

   // Ack sampled mid-cycle
   task automatic wait_ack(input logic [7:0] ofs);
      int n;
      bit seen;
      seen = 1'b0;
      n    = 0;
      while (!seen && n < ACK_TIMEOUT) begin
         @(negedge aclk);
         seen = cfg_ack;
         n++;
      end
      if (!seen) begin
         $display("No cfg_ack within %0d cycles for offset 0x%02h", ACK_TIMEOUT, ofs);
         stop_with_failure();
      end
   endtask

   // ------------------------------------------------
   // Config bus accesses
   // ------------------------------------------------
   task automatic cfg_write(input logic [7:0] ofs, input logic [31:0] data);
      @(posedge aclk);
      cfg_addr  <= {24'h0, ofs};
      cfg_wdata <= data;
      cfg_wr    <= 1'b1;
      @(posedge aclk);
      cfg_wr <= 1'b0;
      wait_ack(ofs);
   endtask

   task automatic cfg_read(input logic [7:0] ofs, output logic [31:0] data);
      @(posedge aclk);
      cfg_addr <= {24'h0, ofs};
      cfg_rd   <= 1'b1;
      @(posedge aclk);
      cfg_rd <= 1'b0;
      wait_ack(ofs);
      // Read data valid in the ack cycle
      data = cfg_rdata;
   endtask

   task automatic check_reg(input logic [7:0] ofs, input logic [31:0] exp);
      logic [31:0] got;
      cfg_read(ofs, got);
      check_value($sformatf("cfg_rdata[0x%02h]", ofs), got, exp);
   endtask

   // Go with Done clear, then poll for Done
   task automatic run_cmd(input logic is_read);
      logic [31:0] ccr_cmd;
      logic [31:0] ccr_exp;
      logic [31:0] status;
      int          polls;
      ccr_cmd             = '0;
      ccr_cmd[CCR_GO]     = 1'b1;
      ccr_cmd[CCR_RD_WRB] = is_read;
      cfg_write(CCR, ccr_cmd);
      status = '0;
      polls  = 0;
      while (!status[CCR_DONE] && polls < POLL_LIMIT) begin
         cfg_read(CCR, status);
         polls++;
      end
      if (!status[CCR_DONE]) begin
         $display("Command stuck, Done still clear after %0d CCR polls", POLL_LIMIT);
         stop_with_failure();
      end
      ccr_exp             = '0;
      ccr_exp[CCR_DONE]   = 1'b1;
      ccr_exp[CCR_RD_WRB] = is_read;
      check_value("cfg_rdata[CCR]", status, ccr_exp);
   endtask

   task automatic mem_write(input logic [31:0] hi, input logic [31:0] lo,
                            input logic [31:0] word);
      cfg_write(CAHR, hi);
      cfg_write(CALR, lo);
      cfg_write(CWDR, word);
      run_cmd(1'b0);
   endtask

   task automatic mem_read_check(input logic [31:0] hi, input logic [31:0] lo,
                                 input logic [31:0] exp);
      cfg_write(CAHR, hi);
      cfg_write(CALR, lo);
      run_cmd(1'b1);
      check_reg(CRDR, exp);
   endtask

   // ------------------------------------------------
   // Main sequence
   // ------------------------------------------------
   initial begin
      int          i;
      logic [31:0] v;
      logic [31:0] status;
      logic [31:0] marker;
      logic [31:0] ccr_val;
      logic [31:0] word_a;
      logic [31:0] word_b;
      logic [3:0]  lane_line;
      logic [5:0]  ofs_a;
      logic [5:0]  ofs_b;

      cfg_addr  <= '0;
      cfg_wdata <= '0;
      cfg_wr    <= 1'b0;
      cfg_rd    <= 1'b0;
      aresetn   <= 1'b0;

      // Table with expected words from the model
      seed = 32'hf1c26318;
      for (i = 0; i < N_ENTRIES; i++) begin
         seed            = lcg_next(seed);
         tbl[i].addr_hi  = seed;
         seed            = lcg_next(seed);
         tbl[i].line     = seed[27:24];
         tbl[i].ofs      = {seed[19:16], 2'b00};
         seed            = lcg_next(seed);
         tbl[i].wr_word  = seed;
         model_write(tbl[i].line, tbl[i].ofs, tbl[i].wr_word);
         tbl[i].exp_word = model_read(tbl[i].line, tbl[i].ofs);
      end

      repeat (16) @(posedge aclk);
      aresetn <= 1'b1;

      // Reset values and unmapped readback
      for (i = 0; i < 5; i++)
         check_reg(all_regs[i], 32'h0);
      check_reg(8'h20, CFG_UNMAPPED);

      // Plain register readback, CRDR included
      for (i = 1; i < 5; i++) begin
         seed = lcg_next(seed);
         v    = seed;
         cfg_write(all_regs[i], v);
         check_reg(all_regs[i], v);
      end

      // Table: write then read back each entry
      for (i = 0; i < N_ENTRIES; i++) begin
         mem_write(tbl[i].addr_hi, line_lo(1'b0, tbl[i].line, tbl[i].ofs), tbl[i].wr_word);
         mem_read_check(tbl[i].addr_hi, line_lo(1'b0, tbl[i].line, tbl[i].ofs),
                        tbl[i].exp_word);
      end

      // Two lanes of one line stay apart
      for (i = 0; i < N_LANE_LINES; i++) begin
         seed      = lcg_next(seed);
         lane_line = seed[11:8];
         ofs_a     = {seed[5:2], 2'b00};
         ofs_b     = ofs_a ^ 6'h20;
         seed      = lcg_next(seed);
         word_a    = seed;
         seed      = lcg_next(seed);
         word_b    = seed;
         mem_write(32'h0, line_lo(1'b0, lane_line, ofs_a), word_a);
         model_write(lane_line, ofs_a, word_a);
         mem_write(32'h0, line_lo(1'b0, lane_line, ofs_b), word_b);
         model_write(lane_line, ofs_b, word_b);
         mem_read_check(32'h0, line_lo(1'b0, lane_line, ofs_a), model_read(lane_line, ofs_a));
         mem_read_check(32'h0, line_lo(1'b0, lane_line, ofs_b), model_read(lane_line, ofs_b));
      end

      // Line index plus 16 folds back
      seed      = lcg_next(seed);
      lane_line = seed[23:20];
      ofs_a     = {seed[9:6], 2'b00};
      seed      = lcg_next(seed);
      word_a    = seed;
      mem_write(32'h0, line_lo(1'b1, lane_line, ofs_a), word_a);
      model_write(lane_line, ofs_a, word_a);
      mem_read_check(32'h0, line_lo(1'b0, lane_line, ofs_a), model_read(lane_line, ofs_a));

      // Go together with Done must not start a read
      seed   = lcg_next(seed);
      marker = seed;
      cfg_write(CRDR, marker);
      ccr_val             = '0;
      ccr_val[CCR_GO]     = 1'b1;
      ccr_val[CCR_DONE]   = 1'b1;
      ccr_val[CCR_RD_WRB] = 1'b1;
      cfg_write(CCR, ccr_val);
      // Master stays idle, so Go is never taken
      for (i = 0; i < 4; i++) begin
         cfg_read(CCR, status);
         check_value("cfg_rdata[CCR]", status, ccr_val);
      end
      check_reg(CRDR, marker);
      // Master still answers a normal command
      mem_read_check(tbl[0].addr_hi, line_lo(1'b0, tbl[0].line, tbl[0].ofs),
                     model_read(tbl[0].line, tbl[0].ofs));

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/dma_mstr_top.sv
// Register-driven master with line memory
`timescale 1ns/1ps
`default_nettype none

module dma_mstr_top
   import axi_line_pkg::*;
#(
   parameter int MEM_LINES = 16
) (
   input  wire         aclk,
   input  wire         aresetn,
   // Config bus
   input  wire  [31:0] cfg_addr,
   input  wire  [31:0] cfg_wdata,
   input  wire         cfg_wr,
   input  wire         cfg_rd,
   output logic        cfg_ack,
   output logic [31:0] cfg_rdata
);

   // Register to master
   logic                  cmd_go;
   logic                  cmd_done;
   logic                  cmd_rd_wrb;
   logic [AXI_ADDR_W-1:0] cmd_addr;
   logic [WORD_W-1:0]     cmd_wr_word;
   logic                  mstr_idle;
   logic                  cmd_complete;
   logic                  rd_word_valid;
   logic [WORD_W-1:0]     rd_word;

   // AXI between master and memory
   logic [AXI_ADDR_W-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;
   logic [AXI_DATA_W-1:0] wdata;
   logic [AXI_STRB_W-1:0] wstrb;
   logic                  wvalid;
   logic                  wready;
   logic                  bvalid;
   logic                  bready;
   logic [AXI_ADDR_W-1:0] araddr;
   logic                  arvalid;
   logic                  arready;
   logic                  rvalid;
   logic [AXI_DATA_W-1:0] rdata;
   logic                  rready;

   // ------------------------------------------------
   // Blocks
   // ------------------------------------------------
   cmd_regs u_cmd_regs (
      .aclk, .aresetn,
      .cfg_addr, .cfg_wdata, .cfg_wr, .cfg_rd, .cfg_ack, .cfg_rdata,
      .mstr_idle, .cmd_complete, .rd_word_valid, .rd_word,
      .cmd_go, .cmd_done, .cmd_rd_wrb, .cmd_addr, .cmd_wr_word
   );

   axi_mstr_fsm u_axi_mstr_fsm (
      .aclk, .aresetn,
      .cmd_go, .cmd_done, .cmd_rd_wrb, .cmd_addr, .cmd_wr_word,
      .mstr_idle, .cmd_complete, .rd_word_valid, .rd_word,
      .awaddr, .awvalid, .awready,
      .wdata, .wstrb, .wvalid, .wready,
      .bvalid, .bready,
      .araddr, .arvalid, .arready,
      .rvalid, .rdata, .rready
   );

   // Memory depth comes from the top
   line_mem #(
      .MEM_LINES (MEM_LINES)
   ) u_line_mem (
      .aclk, .aresetn,
      .awaddr, .awvalid, .awready,
      .wdata, .wstrb, .wvalid, .wready,
      .bvalid, .bready,
      .araddr, .arvalid, .arready,
      .rvalid, .rdata, .rready
   );

endmodule

`default_nettype wire

//--- hw/line_mem.sv
// AXI line memory
`timescale 1ns/1ps
`default_nettype none

module line_mem
   import axi_line_pkg::*;
#(
   parameter int MEM_LINES = 16
) (
   input  wire                   aclk,
   input  wire                   aresetn,
   // Write address
   input  wire  [AXI_ADDR_W-1:0] awaddr,
   input  wire                   awvalid,
   output logic                  awready,
   // Write data
   input  wire  [AXI_DATA_W-1:0] wdata,
   input  wire  [AXI_STRB_W-1:0] wstrb,
   input  wire                   wvalid,
   output logic                  wready,
   // Write response
   output logic                  bvalid,
   input  wire                   bready,
   // Read address
   input  wire  [AXI_ADDR_W-1:0] araddr,
   input  wire                   arvalid,
   output logic                  arready,
   // Read data
   output logic                  rvalid,
   output logic [AXI_DATA_W-1:0] rdata,
   input  wire                   rready
);

   // Line index bits, depth is a power of two
   localparam int IDX_W = $clog2(MEM_LINES);

   logic [AXI_DATA_W-1:0] mem [MEM_LINES];

   logic             aw_taken;
   logic [IDX_W-1:0] wr_idx;

   // ------------------------------------------------
   // Write channel
   // ------------------------------------------------
   // No new address while a write is in flight
   assign awready = ~aw_taken & ~bvalid;
   assign wready  = aw_taken;

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         aw_taken <= 1'b0;
         bvalid   <= 1'b0;
         wr_idx   <= '0;
      end else begin
         if (awvalid && awready) begin
            aw_taken <= 1'b1;
            // Upper address bits fold onto the depth
            wr_idx   <= awaddr[LANE_OFS_W +: IDX_W];
         end
         if (wvalid && wready) begin
            aw_taken <= 1'b0;
            bvalid   <= 1'b1;
         end else if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // Byte-wise merge under the strobes
   always_ff @(posedge aclk) begin
      if (wvalid && wready) begin
         for (int b = 0; b < AXI_STRB_W; b++) begin
            if (wstrb[b])
               mem[wr_idx][b*8 +: 8] <= wdata[b*8 +: 8];
         end
      end
   end

   // ------------------------------------------------
   // Read channel
   // ------------------------------------------------
   assign arready = ~rvalid;

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         rvalid <= 1'b0;
      end else if (arvalid && arready) begin
         rvalid <= 1'b1;
      end else if (rvalid && rready) begin
         rvalid <= 1'b0;
      end
   end

   // Line held until the data handshake
   always_ff @(posedge aclk) begin
      if (arvalid && arready)
         rdata <= mem[araddr[LANE_OFS_W +: IDX_W]];
   end

endmodule

`default_nettype wire

//--- axi_mstr/axi_mstr_fsm.sv
// Single-word AXI master
`timescale 1ns/1ps
`default_nettype none

module axi_mstr_fsm
   import axi_line_pkg::*;
(
   input  wire                   aclk,
   input  wire                   aresetn,
   // Command from the registers
   input  wire                   cmd_go,
   input  wire                   cmd_done,
   input  wire                   cmd_rd_wrb,
   input  wire  [AXI_ADDR_W-1:0] cmd_addr,
   input  wire  [WORD_W-1:0]     cmd_wr_word,
   // Status back to the registers
   output logic                  mstr_idle,
   output logic                  cmd_complete,
   output logic                  rd_word_valid,
   output logic [WORD_W-1:0]     rd_word,
   // Write address
   output logic [AXI_ADDR_W-1:0] awaddr,
   output logic                  awvalid,
   input  wire                   awready,
   // Write data
   output logic [AXI_DATA_W-1:0] wdata,
   output logic [AXI_STRB_W-1:0] wstrb,
   output logic                  wvalid,
   input  wire                   wready,
   // Write response
   input  wire                   bvalid,
   output logic                  bready,
   // Read address
   output logic [AXI_ADDR_W-1:0] araddr,
   output logic                  arvalid,
   input  wire                   arready,
   // Read data
   input  wire                   rvalid,
   input  wire  [AXI_DATA_W-1:0] rdata,
   output logic                  rready
);

   mstr_state_t           state_q;
   mstr_state_t           state_d;
   logic [LANE_OFS_W-1:0] lane_ofs;

   // ------------------------------------------------
   // State machine
   // ------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         // Start only on a fresh Go
         IDLE: begin
            if (cmd_go && !cmd_done)
               state_d = cmd_rd_wrb ? RD_ADDR : WR_ADDR;
         end
         WR_ADDR: begin
            if (awready)
               state_d = WR_DATA;
         end
         WR_DATA: begin
            if (wready)
               state_d = WR_RESP;
         end
         WR_RESP: begin
            if (bvalid)
               state_d = IDLE;
         end
         RD_ADDR: begin
            if (arready)
               state_d = RD_DATA;
         end
         RD_DATA: begin
            if (rvalid)
               state_d = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // ------------------------------------------------
   // Channel controls straight from the state
   // ------------------------------------------------
   assign awvalid = (state_q == WR_ADDR);
   assign wvalid  = (state_q == WR_DATA);
   assign bready  = (state_q == WR_RESP);
   assign arvalid = (state_q == RD_ADDR);
   assign rready  = (state_q == RD_DATA);

   assign mstr_idle = (state_q == IDLE);

   // End of either transaction type
   assign cmd_complete  = (bvalid & bready) | (rvalid & rready);
   assign rd_word_valid = rvalid & rready;

   // ------------------------------------------------
   // Lane handling
   // ------------------------------------------------
   // Both channels use the same command address
   assign awaddr   = cmd_addr;
   assign araddr   = cmd_addr;
   assign lane_ofs = cmd_addr[LANE_OFS_W-1:0];

   assign wdata   = lane_place(cmd_wr_word, lane_ofs);
   assign wstrb   = lane_strb(lane_ofs);
   assign rd_word = lane_extract(rdata, lane_ofs);

endmodule

`default_nettype wire

//--- axi_mstr/cmd_regs.sv
// Command register block
`timescale 1ns/1ps
`default_nettype none

module cmd_regs
   import cmd_reg_pkg::*;
   import axi_line_pkg::*;
(
   input  wire                   aclk,
   input  wire                   aresetn,
   // Config bus
   input  wire  [31:0]           cfg_addr,
   input  wire  [31:0]           cfg_wdata,
   input  wire                   cfg_wr,
   input  wire                   cfg_rd,
   output logic                  cfg_ack,
   output logic [31:0]           cfg_rdata,
   // Status from the master
   input  wire                   mstr_idle,
   input  wire                   cmd_complete,
   input  wire                   rd_word_valid,
   input  wire  [WORD_W-1:0]     rd_word,
   // Command out to the master
   output logic                  cmd_go,
   output logic                  cmd_done,
   output logic                  cmd_rd_wrb,
   output logic [AXI_ADDR_W-1:0] cmd_addr,
   output logic [WORD_W-1:0]     cmd_wr_word
);

   // ------------------------------------------------
   // Access capture
   // ------------------------------------------------
   logic        wr_stretch;
   logic        rd_stretch;
   cmd_reg_t    cfg_addr_q;
   logic [31:0] cfg_wdata_q;
   logic        reg_wr;

   // Registers behind the map
   logic [31:0] addr_hi_q;
   logic [31:0] addr_lo_q;
   logic [31:0] wr_word_q;
   logic [31:0] rd_word_q;
   logic [31:0] ccr_val;

   // Strobe held until the ack cycle
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wr_stretch  <= 1'b0;
         rd_stretch  <= 1'b0;
         cfg_addr_q  <= CCR;
         cfg_wdata_q <= '0;
      end else begin
         wr_stretch <= cfg_wr | (wr_stretch & ~cfg_ack);
         rd_stretch <= cfg_rd | (rd_stretch & ~cfg_ack);
         if (cfg_wr | cfg_rd) begin
            cfg_addr_q  <= cmd_reg_t'(cfg_addr[7:0]);
            cfg_wdata_q <= cfg_wdata;
         end
      end
   end

   // One write slot per access, the cycle before ack
   assign reg_wr = wr_stretch & ~cfg_ack;

   // Ack lands two cycles after the strobe
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         cfg_ack <= 1'b0;
      end else begin
         cfg_ack <= (wr_stretch | rd_stretch) & ~cfg_ack;
      end
   end

   // ------------------------------------------------
   // Command registers
   // ------------------------------------------------
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         cmd_go     <= 1'b0;
         cmd_done   <= 1'b0;
         cmd_rd_wrb <= 1'b0;
      end else if (reg_wr && cfg_addr_q == CCR) begin
         cmd_go     <= cfg_wdata_q[CCR_GO];
         cmd_done   <= cfg_wdata_q[CCR_DONE];
         cmd_rd_wrb <= cfg_wdata_q[CCR_RD_WRB];
      end else begin
         // Go drops once the master has left idle
         cmd_go   <= cmd_go & mstr_idle;
         // Done sticks until software rewrites CCR
         cmd_done <= cmd_done | cmd_complete;
      end
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         addr_hi_q <= '0;
         addr_lo_q <= '0;
         wr_word_q <= '0;
         rd_word_q <= '0;
      end else begin
         if (reg_wr && cfg_addr_q == CAHR)
            addr_hi_q <= cfg_wdata_q;
         if (reg_wr && cfg_addr_q == CALR)
            addr_lo_q <= cfg_wdata_q;
         if (reg_wr && cfg_addr_q == CWDR)
            wr_word_q <= cfg_wdata_q;
         // Software write wins over a finished read
         if (reg_wr && cfg_addr_q == CRDR)
            rd_word_q <= cfg_wdata_q;
         else if (rd_word_valid)
            rd_word_q <= rd_word;
      end
   end

   assign cmd_addr    = {addr_hi_q, addr_lo_q};
   assign cmd_wr_word = wr_word_q;

   // ------------------------------------------------
   // Readback
   // ------------------------------------------------
   always_comb begin
      ccr_val             = '0;
      ccr_val[CCR_GO]     = cmd_go;
      ccr_val[CCR_DONE]   = cmd_done;
      ccr_val[CCR_RD_WRB] = cmd_rd_wrb;
   end

   // Sampled the cycle before ack
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         cfg_rdata <= '0;
      end else begin
         case (cfg_addr_q)
            CCR:     cfg_rdata <= ccr_val;
            CAHR:    cfg_rdata <= addr_hi_q;
            CALR:    cfg_rdata <= addr_lo_q;
            CWDR:    cfg_rdata <= wr_word_q;
            CRDR:    cfg_rdata <= rd_word_q;
            default: cfg_rdata <= CFG_UNMAPPED;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- common/cmd_reg_pkg.sv
// Command register map
`default_nettype none

package cmd_reg_pkg;

   // ------------------------------------------------
   // Register offsets on the config bus
   // ------------------------------------------------
   // Only the low 8 address bits decode here
   typedef enum logic [7:0] {
      // Command control
      CCR  = 8'h00,
      // Address high half
      CAHR = 8'h04,
      // Address low half
      CALR = 8'h08,
      // Write word
      CWDR = 8'h0C,
      // Read word
      CRDR = 8'h10
   } cmd_reg_t;

   // ------------------------------------------------
   // CCR fields
   // ------------------------------------------------
   // Start request, self clearing
   localparam int CCR_GO     = 0;
   // Sticky completion flag
   localparam int CCR_DONE   = 1;
   // 1 for read, 0 for write
   localparam int CCR_RD_WRB = 2;

   // Readback for offsets outside the map
   localparam logic [31:0] CFG_UNMAPPED = 32'hffffffff;

endpackage

`default_nettype wire

//--- common/axi_line_pkg.sv
// AXI line definitions
`default_nettype none

package axi_line_pkg;

   // ------------------------------------------------
   // Bus widths
   // ------------------------------------------------
   localparam int AXI_ADDR_W = 64;
   localparam int AXI_DATA_W = 512;
   localparam int AXI_STRB_W = AXI_DATA_W / 8;
   // Byte offset inside one line
   localparam int LANE_OFS_W = 6;
   // Command word
   localparam int WORD_W     = 32;

   // Master FSM states
   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      WR_ADDR = 3'd1,
      WR_DATA = 3'd2,
      WR_RESP = 3'd3,
      RD_ADDR = 3'd4,
      RD_DATA = 3'd5
   } mstr_state_t;

   // ------------------------------------------------
   // Byte lane helpers
   // ------------------------------------------------

   // Four byte strobes moved up to the lane
   function automatic logic [AXI_STRB_W-1:0] lane_strb(input logic [LANE_OFS_W-1:0] ofs);
      logic [AXI_STRB_W-1:0] base;
      base = {{(AXI_STRB_W-WORD_W/8){1'b0}}, {(WORD_W/8){1'b1}}};
      return base << ofs;
   endfunction

   // Word placed into its byte lane of the beat
   function automatic logic [AXI_DATA_W-1:0] lane_place(input logic [WORD_W-1:0] word,
                                                        input logic [LANE_OFS_W-1:0] ofs);
      logic [AXI_DATA_W-1:0] beat;
      beat = {{(AXI_DATA_W-WORD_W){1'b0}}, word};
      return beat << {ofs, 3'b000};
   endfunction

   // Word pulled back down out of its lane
   function automatic logic [WORD_W-1:0] lane_extract(input logic [AXI_DATA_W-1:0] beat,
                                                      input logic [LANE_OFS_W-1:0] ofs);
      logic [AXI_DATA_W-1:0] shifted;
      shifted = beat >> {ofs, 3'b000};
      return shifted[WORD_W-1:0];
   endfunction

endpackage

`default_nettype wire
